//--- verilog/panel_pkg.sv
`default_nettype none

package panel_pkg;

	// panel buttons and their bit positions.
	localparam int NUM_BUTTONS = 3;
	localparam int BTN_RUN = 0;
	localparam int BTN_MODE = 1;
	localparam int BTN_CLEAR = 2;

	// one bit per button, for raw, clean and press vectors.
	typedef logic [NUM_BUTTONS-1:0] button_vec_t;

	// mode count, wraps 3 -> 0.
	localparam int MODE_WIDTH = 2;
	typedef logic [MODE_WIDTH-1:0] mode_t;

	// sample tick divider, period must be a power of two.
	localparam int TICK_PERIOD = 4;
	localparam int TICK_WIDTH = $clog2(TICK_PERIOD);

	// input conditioning.
	localparam int SYNC_STAGES = 2;
	localparam int DEBOUNCE_TICKS = 8;
	localparam int DEBOUNCE_WIDTH = $clog2(DEBOUNCE_TICKS + 1);

	// indicator timing, all in ticks.
	localparam int BLINK_TICKS = 6; // half period of the run led.
	localparam int BLINK_WIDTH = $clog2(BLINK_TICKS);
	localparam int EXTEND_TICKS = 10; // activity led hold time.
	localparam int EXTEND_WIDTH = $clog2(EXTEND_TICKS);

endpackage

`default_nettype wire

//--- verilog/panel_status_if.sv
`timescale 1ns/1ps
`default_nettype none

interface panel_status_if import panel_pkg::*; ();

	logic run_enable; // level.
	mode_t mode;
	logic activity; // one cycle, any press.
	logic cleared; // one cycle, clear press.

	modport source (
		output run_enable,
		output mode,
		output activity,
		output cleared
	);

	modport sink (
		input run_enable,
		input mode,
		input activity,
		input cleared
	);

endinterface

`default_nettype wire

//--- verilog/tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tick_gen import panel_pkg::*; (
	input logic clk,
	input logic reset,
	output logic tick
);

	logic [TICK_WIDTH-1:0] count;

	// free running, wraps on its own since the period is a power of two.
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// first tick lands TICK_PERIOD-1 cycles after reset.
	assign tick = (count == TICK_WIDTH'(TICK_PERIOD - 1));

endmodule

`default_nettype wire

//--- verilog/button_conditioner.sv
`timescale 1ns/1ps
`default_nettype none

module button_conditioner import panel_pkg::*; (
	input logic clk,
	input logic reset,
	input logic tick,
	input button_vec_t raw,
	output button_vec_t clean,
	output button_vec_t press
);

	genvar i;

	for (i = 0; i < NUM_BUTTONS; i++) begin : g_button
		logic [SYNC_STAGES-1:0] sync_q;
		logic synced;
		logic last_q; // last synchronized value seen.
		logic [DEBOUNCE_WIDTH-1:0] count;
		logic stable;
		logic clean_q;
		logic prev_q;

		// two-flop synchronizer, oldest bit on the left.
		always_ff @(posedge clk) begin
			if (reset) begin
				sync_q <= '0;
			end else begin
				sync_q <= {sync_q[SYNC_STAGES-2:0], raw[i]};
			end
		end

		assign synced = sync_q[SYNC_STAGES-1];
		assign stable = (count == DEBOUNCE_WIDTH'(DEBOUNCE_TICKS));

		// any change restarts the stability count.
		always_ff @(posedge clk) begin
			if (reset) begin
				last_q <= 1'b0;
				count <= '0;
			end else if (synced != last_q) begin
				last_q <= synced;
				count <= '0;
			end else if (tick && !stable) begin
				count <= count + 1'b1; // saturates at threshold.
			end
		end

		always_ff @(posedge clk) begin
			if (reset) begin
				clean_q <= 1'b0;
			end else if (stable) begin
				clean_q <= last_q;
			end
		end

		// previous clean level for rising edge detect.
		always_ff @(posedge clk) begin
			if (reset) begin
				prev_q <= 1'b0;
			end else begin
				prev_q <= clean_q;
			end
		end

		assign clean[i] = clean_q;
		assign press[i] = clean_q & ~prev_q;
	end

endmodule

`default_nettype wire

//--- verilog/mode_control.sv
`timescale 1ns/1ps
`default_nettype none

module mode_control import panel_pkg::*; (
	input logic clk,
	input logic reset,
	input button_vec_t press,
	input button_vec_t clean,
	panel_status_if.source status
);

	logic run_enable_q;
	mode_t mode_q;
	logic activity_q;
	logic cleared_q;

	logic run_press;
	logic clear_press;
	logic mode_step;

	assign run_press = press[BTN_RUN];
	assign clear_press = press[BTN_CLEAR];

	// clear held or pressed blocks the step, so clear wins.
	assign mode_step = press[BTN_MODE] && !clean[BTN_CLEAR];

	always_ff @(posedge clk) begin
		if (reset) begin
			run_enable_q <= 1'b0;
		end else if (run_press) begin
			run_enable_q <= ~run_enable_q;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mode_q <= '0;
		end else if (clear_press) begin
			mode_q <= '0;
		end else if (mode_step) begin
			mode_q <= mode_q + mode_t'(1); // wraps to 0.
		end
	end

	// strobes, one cycle after the press pulse.
	always_ff @(posedge clk) begin
		if (reset) begin
			activity_q <= 1'b0;
			cleared_q <= 1'b0;
		end else begin
			activity_q <= |press;
			cleared_q <= clear_press;
		end
	end

	assign status.run_enable = run_enable_q;
	assign status.mode = mode_q;
	assign status.activity = activity_q;
	assign status.cleared = cleared_q;

endmodule

`default_nettype wire

//--- verilog/indicator_driver.sv
`timescale 1ns/1ps
`default_nettype none

module indicator_driver import panel_pkg::*; (
	input logic clk,
	input logic reset,
	input logic tick,
	panel_status_if.sink status,
	output logic led_run,
	output logic led_activity
);

	logic [BLINK_WIDTH-1:0] blink_count;
	logic blink_wrap;
	logic led_run_q;

	logic [EXTEND_WIDTH-1:0] extend_count;
	logic extend_done;
	logic led_activity_q;

	assign blink_wrap = (blink_count == BLINK_WIDTH'(BLINK_TICKS - 1));
	assign extend_done = (extend_count == EXTEND_WIDTH'(EXTEND_TICKS - 1));

	// run led blinker, a clear restarts the phase from dark.
	always_ff @(posedge clk) begin
		if (reset || !status.run_enable || status.cleared) begin
			blink_count <= '0;
			led_run_q <= 1'b0;
		end else if (tick) begin
			if (blink_wrap) begin
				blink_count <= '0;
				led_run_q <= ~led_run_q;
			end else begin
				blink_count <= blink_count + 1'b1;
			end
		end
	end

	// activity pulse extender.
	always_ff @(posedge clk) begin
		if (reset) begin
			extend_count <= '0;
			led_activity_q <= 1'b0;
		end else if (status.activity) begin
			extend_count <= '0; // retrigger.
			led_activity_q <= 1'b1;
		end else if (led_activity_q && tick) begin
			if (extend_done) begin
				extend_count <= '0;
				led_activity_q <= 1'b0;
			end else begin
				extend_count <= extend_count + 1'b1;
			end
		end
	end

	assign led_run = led_run_q;
	assign led_activity = led_activity_q;

endmodule

`default_nettype wire

//--- verilog/front_panel.sv
`timescale 1ns/1ps
`default_nettype none

module front_panel import panel_pkg::*; (
	input logic clk,
	input logic reset,
	input button_vec_t buttons,
	output logic led_run,
	output logic led_activity,
	output logic run_enable,
	output mode_t mode
);

	logic tick;
	button_vec_t clean;
	button_vec_t press;

	panel_status_if status_if ();

	tick_gen tick_gen_i (
		.clk (clk),
		.reset (reset),
		.tick (tick)
	);

	button_conditioner button_conditioner_i (
		.clk (clk),
		.reset (reset),
		.tick (tick),
		.raw (buttons),
		.clean (clean),
		.press (press)
	);

	mode_control mode_control_i (
		.clk (clk),
		.reset (reset),
		.press (press),
		.clean (clean),
		.status (status_if.source)
	);

	indicator_driver indicator_driver_i (
		.clk (clk),
		.reset (reset),
		.tick (tick),
		.status (status_if.sink),
		.led_run (led_run),
		.led_activity (led_activity)
	);

	// control state also goes straight to the pins.
	assign run_enable = status_if.run_enable;
	assign mode = status_if.mode;

endmodule

`default_nettype wire

//--- verif/front_panel_tests.svh
`ifndef FRONT_PANEL_TESTS_SVH
`define FRONT_PANEL_TESTS_SVH

// hold a button long enough to debounce, then release it the same time.
task automatic press_button(input int idx);
	@(posedge clk);
	buttons[idx] <= 1'b1;
	repeat (HOLD_CYCLES) @(posedge clk);
	buttons[idx] <= 1'b0;
	repeat (HOLD_CYCLES) @(posedge clk);
	@(negedge clk); // sample away from the edge.
endtask

task automatic check_reset_state();
	int errors_before;
	errors_before = error_count;
	@(negedge clk);
	compare_mode(mode, '0, "mode after reset");
	compare_bit(run_enable, 1'b0, "run_enable after reset");
	compare_bit(led_run, 1'b0, "led_run after reset");
	compare_bit(led_activity, 1'b0, "led_activity after reset");
	report_test("reset state", errors_before);
endtask

task automatic step_mode();
	int errors_before;
	errors_before = error_count;
	for (int n = 0; n < 5; n++) begin
		press_button(BTN_MODE);
		model_mode = model_mode + mode_t'(1);
		compare_mode(mode, model_mode, "mode after mode press");
	end
	compare_mode(mode, mode_t'(1), "mode after five presses");
	report_test("mode stepping", errors_before);
endtask

task automatic reject_glitches();
	int errors_before;
	int len;
	errors_before = error_count;
	for (int n = 0; n < GLITCH_COUNT; n++) begin
		len = 1 + int'($urandom % GLITCH_MAX);
		@(posedge clk);
		buttons[BTN_MODE] <= 1'b1;
		repeat (len) @(posedge clk);
		buttons[BTN_MODE] <= 1'b0;
		len = int'($urandom % GLITCH_MAX); // the next edge adds one cycle.
		repeat (len) @(posedge clk);
	end
	repeat (HOLD_CYCLES) @(posedge clk);
	@(negedge clk);
	compare_mode(mode, model_mode, "mode after glitches");
	report_test("glitch rejection", errors_before);
endtask

task automatic toggle_run_blink();
	int errors_before;
	logic seen_high;
	logic seen_low;
	errors_before = error_count;
	press_button(BTN_RUN);
	model_run = ~model_run;
	compare_bit(run_enable, model_run, "run_enable after first run press");
	seen_high = 1'b0;
	seen_low = 1'b0;
	repeat (BLINK_WINDOW) begin
		@(negedge clk);
		seen_high = seen_high | led_run;
		seen_low = seen_low | ~led_run;
	end
	compare_bit(seen_high, 1'b1, "led_run seen high while running");
	compare_bit(seen_low, 1'b1, "led_run seen low while running");
	press_button(BTN_RUN);
	model_run = ~model_run;
	compare_bit(run_enable, model_run, "run_enable after second run press");
	seen_high = 1'b0;
	repeat (BLINK_WINDOW) begin
		@(negedge clk);
		seen_high = seen_high | led_run;
	end
	compare_bit(seen_high, 1'b0, "led_run seen high while stopped");
	report_test("run toggle and blink", errors_before);
endtask

task automatic extend_activity();
	int errors_before;
	int waited;
	mode_t expected;
	errors_before = error_count;
	expected = model_mode + mode_t'(1);
	@(posedge clk);
	buttons[BTN_MODE] <= 1'b1;
	waited = 0;
	@(negedge clk);
	while (mode !== expected && waited < 2 * HOLD_CYCLES) begin
		@(negedge clk);
		waited++;
	end
	if (mode !== expected) begin
		$display("mode press was not detected within %0d cycles", 2 * HOLD_CYCLES);
		error_count++;
	end
	model_mode = expected;
	@(negedge clk); // led follows the strobe by one cycle.
	compare_bit(led_activity, 1'b1, "led_activity after press");
	@(posedge clk);
	buttons[BTN_MODE] <= 1'b0;
	repeat (EXTEND_WAIT) @(posedge clk);
	@(negedge clk);
	compare_bit(led_activity, 1'b0, "led_activity after extension");
	report_test("activity extension", errors_before);
endtask

task automatic clear_mode();
	int errors_before;
	errors_before = error_count;
	if (!model_run) begin
		press_button(BTN_RUN);
		model_run = 1'b1;
	end
	if (model_mode == '0) begin
		press_button(BTN_MODE);
		model_mode = mode_t'(1);
	end
	compare_bit(run_enable, 1'b1, "run_enable before clear");
	press_button(BTN_CLEAR);
	model_mode = '0;
	compare_mode(mode, model_mode, "mode after clear");
	compare_bit(run_enable, 1'b1, "run_enable after clear");
	report_test("clear", errors_before);
endtask

`endif

//--- verif/front_panel_tb.sv
`timescale 1ns/1ps
`default_nettype none

module front_panel_tb import panel_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int HOLD_CYCLES = (DEBOUNCE_TICKS + 3) * TICK_PERIOD;
	localparam int GLITCH_MAX = (DEBOUNCE_TICKS - 1) * TICK_PERIOD - 1; // longest glitch.
	localparam int GLITCH_COUNT = 12;
	localparam int BLINK_WINDOW = 2 * BLINK_TICKS * TICK_PERIOD + 2;
	localparam int EXTEND_WAIT = (EXTEND_TICKS + 2) * TICK_PERIOD;

	// worst case per test, in clock cycles.
	localparam int TEST_CYCLES = 4
		+ 5 * 2 * HOLD_CYCLES
		+ GLITCH_COUNT * 2 * GLITCH_MAX + HOLD_CYCLES
		+ 2 * 2 * HOLD_CYCLES + 2 * BLINK_WINDOW
		+ 2 * HOLD_CYCLES + EXTEND_WAIT
		+ 3 * 2 * HOLD_CYCLES + 16;

	logic clk = 1'b0;
	logic reset;
	button_vec_t buttons;
	logic led_run;
	logic led_activity;
	logic run_enable;
	mode_t mode;

	int error_count = 0;
	int pass_count = 0;
	int fail_count = 0;
	mode_t model_mode = '0; // expected mode count.
	logic model_run = 1'b0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	front_panel front_panel_i (
		.clk (clk),
		.reset (reset),
		.buttons (buttons),
		.led_run (led_run),
		.led_activity (led_activity),
		.run_enable (run_enable),
		.mode (mode)
	);

	task automatic compare_mode(input mode_t actual, input mode_t expected, input string what);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns: %s expected %0d, got %0d", $time, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic compare_bit(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns: %s expected %b, got %b", $time, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			pass_count++;
			$display("test %s: ok", name);
		end else begin
			fail_count++;
			$display("test %s: %0d errors", name, error_count - errors_before);
		end
	endtask

	`include "front_panel_tests.svh"

	initial begin
		void'($urandom(32'hb61e_afcd));
		reset = 1'b1;
		buttons = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		check_reset_state();
		step_mode();
		reject_glitches();
		toggle_run_blink();
		extend_activity();
		clear_mode();
		$display("tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// twice the summed worst case of all tests.
	initial begin : watchdog
		#(2 * TEST_CYCLES * CLK_PERIOD);
		$display("watchdog: simulation ran past its time limit, tests did not complete");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- front_panel.f
+incdir+verif
verilog/panel_pkg.sv
verilog/panel_status_if.sv
verilog/tick_gen.sv
verilog/button_conditioner.sv
verilog/mode_control.sv
verilog/indicator_driver.sv
verilog/front_panel.sv
verif/front_panel_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the front panel testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f front_panel.f --top-module front_panel_tb \
	-o front_panel_sim \
	&& ./obj_dir/front_panel_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TESTBENCH PASSED" sim.log \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed"; exit 1; }
